// ==== Bender.yml ====
package:
  name: sprite_render

sources:
  - hw/spritePkg.sv
  - hw/keyDecode.sv
  - hw/playerMotion.sv
  - hw/attackSprite.sv
  - hw/pixelCompose.sv
  - hw/spriteRender.sv
  - target: test
    files:
      - test/renderChecker.sv
      - test/renderTb.sv

// ==== files.f ====
hw/spritePkg.sv
hw/keyDecode.sv
hw/playerMotion.sv
hw/attackSprite.sv
hw/pixelCompose.sv
hw/spriteRender.sv
test/renderChecker.sv
test/renderTb.sv

// ==== hw/attackSprite.sv ====
// Per-pixel hit test for the player box and the attack strip
// Purely combinational, result is valid in the cycle scanPos is given
// Strip shape follows the facing direction, attack wins over player

module attackSprite import spritePkg::*; #(
    parameter int AttackLength = 64
) (
    input  gameStateT state,
    input  scanPosT   scanPos,
    output hitT       hit
);

    localparam int TileMask = SpriteSize - 1;

    // All geometry in int so edge comparisons never wrap
    int   px;
    int   py;
    int   bx;
    int   by;
    int   ax;
    int   ay;
    int   dx;
    int   dy;
    int   stripAddr;
    int   boxAddr;
    logic inStrip;
    logic inBox;

    assign px = int'(scanPos.x);
    assign py = int'(scanPos.y);
    assign bx = int'(state.playerX);
    assign by = int'(state.playerY);

    // Strip anchor moves past the sprite for Down and Right
    always_comb begin
        ax = bx;
        ay = by;
        if (state.facing == Right) begin
            ax = bx + SpriteSize;
        end
        if (state.facing == Down) begin
            ay = by + SpriteSize;
        end
    end

    assign dx = px - ax;
    assign dy = py - ay;

    always_comb begin
        inStrip   = 1'b0;
        stripAddr = 0;
        case (state.facing)
            Down: begin
                inStrip = (px >= ax) && (px < ax + SpriteSize) &&
                          (py >= ay) && (py < ay + AttackLength);
                stripAddr = dx + (dy & TileMask) * SpriteSize;
            end
            Left: begin
                // Covers the sprite column as well as the reach to the left
                inStrip = (px + AttackLength >= ax) && (px < ax + SpriteSize) &&
                          (py >= ay) && (py < ay + SpriteSize);
                stripAddr = ((ax - px) & TileMask) + dy * SpriteSize;
            end
            Up: begin
                inStrip = (px >= ax) && (px < ax + SpriteSize) &&
                          (py + AttackLength >= ay) && (py < ay + SpriteSize);
                stripAddr = dx + ((ay - py) & TileMask) * SpriteSize;
            end
            Right: begin
                inStrip = (px >= ax) && (px < ax + AttackLength) &&
                          (py >= ay) && (py < ay + SpriteSize);
                stripAddr = (dx & TileMask) + dy * SpriteSize;
            end
            default: begin
            end
        endcase
    end

    // Player box sits at the raw player position
    assign inBox = (px >= bx) && (px < bx + SpriteSize) &&
                   (py >= by) && (py < by + SpriteSize);
    assign boxAddr = (px - bx) + (py - by) * SpriteSize;

    always_comb begin
        if (state.attackOn && inStrip) begin
            hit.layer      = Attack;
            hit.spriteAddr = 8'(stripAddr);
        end else if (inBox) begin
            hit.layer      = Player;
            hit.spriteAddr = 8'(boxAddr);
        end else begin
            hit.layer      = Background;
            hit.spriteAddr = '0;
        end
    end

endmodule

// ==== hw/keyDecode.sv ====
// Frame tick edge detection and keycode decode
// frameTick is treated as asynchronous and passes one sync flop first
// Edges arriving while a frame is still rendering are dropped

module keyDecode import spritePkg::*; (
    input  logic       Clk,
    input  logic       rst,
    input  logic       frameTick,
    input  logic [7:0] keycode,
    input  logic       busy,
    output logic       tickAccept,
    output actionT     action
);

    logic   tickSync;
    logic   tickPrev;
    logic   tickEdge;
    actionT decoded;

    assign tickEdge = tickSync & ~tickPrev;

    // Only WASD move, only space attacks
    always_comb begin
        decoded = '0;
        case (keycode)
            KeyW: begin
                decoded.move    = 1'b1;
                decoded.moveDir = Up;
            end
            KeyA: begin
                decoded.move    = 1'b1;
                decoded.moveDir = Left;
            end
            KeyS: begin
                decoded.move    = 1'b1;
                decoded.moveDir = Down;
            end
            KeyD: begin
                decoded.move    = 1'b1;
                decoded.moveDir = Right;
            end
            KeySpace: decoded.attack = 1'b1;
            default: begin
            end
        endcase
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            tickSync   <= 1'b0;
            tickPrev   <= 1'b0;
            tickAccept <= 1'b0;
        end else begin
            tickSync   <= frameTick;
            tickPrev   <= tickSync;
            tickAccept <= tickEdge & ~busy;
        end
    end

    // Action is sampled with the edge, read only on tickAccept
    always_ff @(posedge Clk) begin
        if (tickEdge) begin
            action <= decoded;
        end
    end

endmodule

// ==== hw/pixelCompose.sv ====
// Raster walker with credit-based output to the line buffer
// The consumer must take every valid pixel and return one credit each
// creditReturn must never exceed the pixels actually sent

module pixelCompose import spritePkg::*; #(
    parameter int FrameWidth  = 320,
    parameter int FrameHeight = 240,
    parameter int CreditDepth = 8
) (
    input  logic    Clk,
    input  logic    rst,
    input  logic    frameStart,
    input  hitT     hit,
    input  logic    creditReturn,
    output scanPosT scanPos,
    output logic    busy,
    output logic    pixelValid,
    output pixelT   pixel
);

    localparam int    CreditWidth = $clog2(CreditDepth + 1);
    localparam coordT LastX       = coordT'(FrameWidth - 1);
    localparam coordT LastY       = coordT'(FrameHeight - 1);

    coordT                  scanX;
    coordT                  scanY;
    logic                   active;
    logic [CreditWidth-1:0] credits;
    logic                   issue;
    logic                   lastPos;

    assign scanPos.x = scanX;
    assign scanPos.y = scanY;

    // First position goes out in the frameStart cycle itself
    assign issue   = (active | frameStart) & (credits != '0);
    assign lastPos = (scanX == LastX) && (scanY == LastY);

    // Busy until the pixel carrying last has left
    assign busy = active | frameStart | pixelValid;

    always_ff @(posedge Clk) begin
        if (rst) begin
            credits <= CreditWidth'(CreditDepth);
        end else begin
            case ({issue, creditReturn})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // Raster counters rest at the origin between frames
    always_ff @(posedge Clk) begin
        if (rst) begin
            active <= 1'b0;
            scanX  <= '0;
            scanY  <= '0;
        end else begin
            if (frameStart) begin
                active <= 1'b1;
            end
            if (issue) begin
                if (scanX == LastX) begin
                    scanX <= '0;
                    if (scanY == LastY) begin
                        scanY  <= '0;
                        active <= 1'b0;
                    end else begin
                        scanY <= scanY + 1'b1;
                    end
                end else begin
                    scanX <= scanX + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            pixelValid <= 1'b0;
        end else begin
            pixelValid <= issue;
        end
    end

    always_ff @(posedge Clk) begin
        if (issue) begin
            pixel.pos  <= scanPos;
            pixel.hit  <= hit;
            pixel.last <= lastPos;
        end
    end

endmodule

// ==== hw/playerMotion.sv ====
// Player position, facing and attack state
// Updated once per accepted tick, frameStart follows one cycle later
// Position is clamped so the whole sprite stays on screen

module playerMotion import spritePkg::*; #(
    parameter int FrameWidth  = 320,
    parameter int FrameHeight = 240,
    parameter int StepSize    = 2
) (
    input  logic      Clk,
    input  logic      rst,
    input  logic      tickAccept,
    input  actionT    action,
    output gameStateT state,
    output logic      frameStart
);

    localparam int MaxX = FrameWidth - SpriteSize;
    localparam int MaxY = FrameHeight - SpriteSize;

    // Player starts centred on screen
    localparam coordT StartX = coordT'(FrameWidth / 2 - SpriteSize / 2);
    localparam coordT StartY = coordT'(FrameHeight / 2 - SpriteSize / 2);

    gameStateT nextState;

    // Widened add so a step past either edge clamps instead of wrapping
    function automatic coordT stepClamp(coordT pos, int delta, int maxPos);
        int target;
        target = int'(pos) + delta;
        if (target < 0) begin
            return '0;
        end else if (target > maxPos) begin
            return coordT'(maxPos);
        end
        return coordT'(target);
    endfunction

    always_comb begin
        nextState = state;
        // Attack lasts one frame and is not implied by a move
        nextState.attackOn = action.attack;
        if (action.move) begin
            nextState.facing = action.moveDir;
            case (action.moveDir)
                Down:  nextState.playerY = stepClamp(state.playerY, StepSize, MaxY);
                Up:    nextState.playerY = stepClamp(state.playerY, -StepSize, MaxY);
                Left:  nextState.playerX = stepClamp(state.playerX, -StepSize, MaxX);
                Right: nextState.playerX = stepClamp(state.playerX, StepSize, MaxX);
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            state.playerX  <= StartX;
            state.playerY  <= StartY;
            state.facing   <= Down;
            state.attackOn <= 1'b0;
            frameStart     <= 1'b0;
        end else begin
            frameStart <= tickAccept;
            if (tickAccept) begin
                state <= nextState;
            end
        end
    end

endmodule

// ==== hw/spritePkg.sv ====
// Shared types and constants for the sprite layer
// Coordinates are 9 bits, so frame dimensions must stay below 512
// Sprite ROM addressing assumes a 16x16 sprite, 8-bit address

package spritePkg;

    // Edge length of the player sprite and the attack tiles
    localparam int SpriteSize = 16;

    // USB HID keycodes used by the game
    localparam logic [7:0] KeySpace = 8'd44;
    localparam logic [7:0] KeyW     = 8'd26;
    localparam logic [7:0] KeyA     = 8'd4;
    localparam logic [7:0] KeyS     = 8'd22;
    localparam logic [7:0] KeyD     = 8'd7;

    typedef logic [8:0] coordT;

    typedef enum logic [1:0] {
        Down  = 2'd0,
        Left  = 2'd1,
        Up    = 2'd2,
        Right = 2'd3
    } dirT;

    typedef enum logic [1:0] {
        Background = 2'd0,
        Player     = 2'd1,
        Attack     = 2'd2
    } layerT;

    // Decoded key for one frame tick
    typedef struct packed {
        logic move;
        dirT  moveDir;
        logic attack;
    } actionT;

    typedef struct packed {
        coordT playerX;
        coordT playerY;
        dirT   facing;
        logic  attackOn;
    } gameStateT;

    typedef struct packed {
        coordT x;
        coordT y;
    } scanPosT;

    // Layer code plus sprite ROM address, colour lookup is downstream
    typedef struct packed {
        layerT      layer;
        logic [7:0] spriteAddr;
    } hitT;

    typedef struct packed {
        scanPosT pos;
        hitT     hit;
        logic    last;
    } pixelT;

endpackage

// ==== hw/spriteRender.sv ====
// Sprite layer top level, one frame per rising edge of frameTick
// Output is a stream of layer code plus ROM address per pixel
// FrameWidth and FrameHeight must be at least SpriteSize and below 512

module spriteRender import spritePkg::*; #(
    parameter int FrameWidth   = 320,
    parameter int FrameHeight  = 240,
    parameter int AttackLength = 64,
    parameter int StepSize     = 2,
    parameter int CreditDepth  = 8
) (
    input  logic       Clk,
    input  logic       rst,
    input  logic       frameTick,
    input  logic [7:0] keycode,
    input  logic       creditReturn,
    output logic       pixelValid,
    output pixelT      pixel
);

    logic      tickAccept;
    actionT    action;
    gameStateT state;
    logic      frameStart;
    logic      busy;
    scanPosT   scanPos;
    hitT       hit;

    keyDecode keyDecode_i (
        .Clk        (Clk),
        .rst        (rst),
        .frameTick  (frameTick),
        .keycode    (keycode),
        .busy       (busy),
        .tickAccept (tickAccept),
        .action     (action)
    );

    playerMotion #(
        .FrameWidth  (FrameWidth),
        .FrameHeight (FrameHeight),
        .StepSize    (StepSize)
    ) playerMotion_i (
        .Clk        (Clk),
        .rst        (rst),
        .tickAccept (tickAccept),
        .action     (action),
        .state      (state),
        .frameStart (frameStart)
    );

    attackSprite #(
        .AttackLength (AttackLength)
    ) attackSprite_i (
        .state   (state),
        .scanPos (scanPos),
        .hit     (hit)
    );

    pixelCompose #(
        .FrameWidth  (FrameWidth),
        .FrameHeight (FrameHeight),
        .CreditDepth (CreditDepth)
    ) pixelCompose_i (
        .Clk          (Clk),
        .rst          (rst),
        .frameStart   (frameStart),
        .hit          (hit),
        .creditReturn (creditReturn),
        .scanPos      (scanPos),
        .busy         (busy),
        .pixelValid   (pixelValid),
        .pixel        (pixel)
    );

endmodule

// ==== test/renderChecker.sv ====
// Reference game model and pixel checker for spriteRender
// Follows frame kicks from the testbench, so a dropped tick must not add a frame
// Samples DUT outputs on the rising clock edge

module renderChecker import spritePkg::*; #(
    parameter int FrameWidth   = 64,
    parameter int FrameHeight  = 48,
    parameter int AttackLength = 32,
    parameter int StepSize     = 4,
    parameter int CreditDepth  = 4
) (
    input logic       Clk,
    input logic       rst,
    input logic       frameKick,
    input logic [7:0] frameKey,
    input logic       frameAttack,
    input logic       pixelValid,
    input pixelT      pixel,
    input logic       creditReturn
);

    int   modelX;
    int   modelY;
    dirT  modelFacing;
    logic modelAttack;
    logic wantAttack;
    logic attackSeen;
    int   expectX;
    int   expectY;
    int   framesKicked = 0;
    int   framesDone   = 0;
    int   outstanding  = 0;
    int   pixelErrors  = 0;
    int   frameErrors  = 0;
    int   creditErrors = 0;

    function automatic int clampTo(int v, int hi);
        return (v < 0) ? 0 : ((v > hi) ? hi : v);
    endfunction

    // Non-negative remainder within one tile
    function automatic int tileMod(int v);
        return ((v % SpriteSize) + SpriteSize) % SpriteSize;
    endfunction

    task automatic applyKey(logic [7:0] key);
        modelAttack = (key == KeySpace);
        if (key == KeyW) begin
            modelY      = clampTo(modelY - StepSize, FrameHeight - SpriteSize);
            modelFacing = Up;
        end else if (key == KeyS) begin
            modelY      = clampTo(modelY + StepSize, FrameHeight - SpriteSize);
            modelFacing = Down;
        end else if (key == KeyA) begin
            modelX      = clampTo(modelX - StepSize, FrameWidth - SpriteSize);
            modelFacing = Left;
        end else if (key == KeyD) begin
            modelX      = clampTo(modelX + StepSize, FrameWidth - SpriteSize);
            modelFacing = Right;
        end
    endtask

    function automatic hitT expectedHit(int x, int y);
        int  ax;
        int  ay;
        int  xLo;
        int  xHi;
        int  yLo;
        int  yHi;
        int  addr;
        hitT want;
        ax  = modelX + ((modelFacing == Right) ? SpriteSize : 0);
        ay  = modelY + ((modelFacing == Down) ? SpriteSize : 0);
        xLo = ax;
        xHi = ax + SpriteSize;
        yLo = ay;
        yHi = ay + SpriteSize;
        case (modelFacing)
            Down: begin
                yHi  = ay + AttackLength;
                addr = (x - ax) + tileMod(y - ay) * SpriteSize;
            end
            Right: begin
                xHi  = ax + AttackLength;
                addr = tileMod(x - ax) + (y - ay) * SpriteSize;
            end
            Left: begin
                xLo  = ax - AttackLength;
                addr = tileMod(ax - x) + (y - ay) * SpriteSize;
            end
            default: begin
                yLo  = ay - AttackLength;
                addr = (x - ax) + tileMod(ay - y) * SpriteSize;
            end
        endcase
        want.layer      = Background;
        want.spriteAddr = '0;
        if (modelAttack && x >= xLo && x < xHi && y >= yLo && y < yHi) begin
            want.layer      = Attack;
            want.spriteAddr = 8'(addr);
        end else if (x >= modelX && x < modelX + SpriteSize &&
                     y >= modelY && y < modelY + SpriteSize) begin
            want.layer      = Player;
            want.spriteAddr = 8'((x - modelX) + (y - modelY) * SpriteSize);
        end
        return want;
    endfunction

    task automatic reportValue(string name, int want, int got);
        pixelErrors++;
        $display("FAIL t=%0t %s expected %0d got %0d", $time, name, want, got);
    endtask

    task automatic checkPixel();
        hitT  want;
        logic wantLast;
        if (framesDone == framesKicked) begin
            frameErrors++;
            $display("Error at t=%0t: pixel sent while no frame was started", $time);
            return;
        end
        want     = expectedHit(expectX, expectY);
        wantLast = (expectX == FrameWidth - 1) && (expectY == FrameHeight - 1);
        if (int'(pixel.pos.x) != expectX) reportValue("pixel.pos.x", expectX, pixel.pos.x);
        if (int'(pixel.pos.y) != expectY) reportValue("pixel.pos.y", expectY, pixel.pos.y);
        if (pixel.hit.layer != want.layer) begin
            reportValue("pixel.hit.layer", want.layer, pixel.hit.layer);
        end
        if (pixel.hit.spriteAddr != want.spriteAddr) begin
            reportValue("pixel.hit.spriteAddr", want.spriteAddr, pixel.hit.spriteAddr);
        end
        if (pixel.last != wantLast) reportValue("pixel.last", wantLast, pixel.last);
        if (pixel.hit.layer == Attack) attackSeen = 1'b1;
        if (wantLast) begin
            framesDone++;
            if (attackSeen != wantAttack) begin
                frameErrors++;
                $display("FAIL t=%0t frame attack flag expected %0d got %0d",
                         $time, wantAttack, attackSeen);
            end
        end else begin
            expectX++;
            if (expectX == FrameWidth) begin
                expectX = 0;
                expectY++;
            end
        end
    endtask

    always @(posedge Clk) begin
        if (rst) begin
            modelX      = FrameWidth / 2 - 8;
            modelY      = FrameHeight / 2 - 8;
            modelFacing = Down;
            modelAttack = 1'b0;
        end else begin
            if (frameKick) begin
                if (framesDone != framesKicked) begin
                    frameErrors++;
                    $display("Error at t=%0t: new frame started before the last one ended", $time);
                end
                applyKey(frameKey);
                framesKicked++;
                wantAttack = frameAttack;
                attackSeen = 1'b0;
                expectX    = 0;
                expectY    = 0;
            end
            if (pixelValid) checkPixel();
            // Sent pixels minus returned credits
            outstanding = outstanding + int'(pixelValid) - int'(creditReturn);
            if (outstanding > CreditDepth) begin
                creditErrors++;
                $display("Error at t=%0t: %0d pixels outstanding, more than the %0d credits",
                         $time, outstanding, CreditDepth);
            end
            if (outstanding < 0) begin
                creditErrors++;
                $display("Error at t=%0t: credit returned with no pixel outstanding", $time);
                outstanding = 0;
            end
        end
    end

    task finishChecks();
        if (framesDone != framesKicked) begin
            frameErrors++;
            $display("Error: only %0d of %0d frames completed", framesDone, framesKicked);
        end
        if (outstanding != 0) begin
            creditErrors++;
            $display("Error: %0d credits never returned", outstanding);
        end
        $display("Checks done: %0d frames, %0d pixel errors, %0d frame errors, %0d credit errors",
                 framesDone, pixelErrors, frameErrors, creditErrors);
    endtask

    function int totalErrors();
        return pixelErrors + frameErrors + creditErrors;
    endfunction

endmodule

// ==== test/renderTb.sv ====
// Testbench for spriteRender with a credit-returning line buffer model
// One frame per applied table row, inputs change on the falling edge
// Credit return delays of 0 to 3 cycles come from $urandom, seed 72

module renderTb import spritePkg::*; ();

    localparam int FrameWidth   = 64;
    localparam int FrameHeight  = 48;
    localparam int AttackLength = 32;
    localparam int StepSize     = 4;
    localparam int CreditDepth  = 4;
    localparam int FramePixels  = FrameWidth * FrameHeight;
    localparam int FrameTimeout = 20 * FramePixels;
    localparam int DrainTimeout = 100;
    localparam int RowCount     = 14;

    // One table row, applied reps times in a row
    typedef struct packed {
        logic [7:0] key;
        logic       attack;
        logic [3:0] reps;
        logic       midTick;
    } stimRowT;

    logic        Clk;
    logic        rst;
    logic        frameTick;
    logic [7:0]  keycode;
    logic        creditReturn;
    logic        pixelValid;
    pixelT       pixel;
    logic        frameKick;
    logic [7:0]  frameKey;
    logic        frameAttack;
    logic        timedOut;
    stimRowT     stimRows [RowCount];
    int unsigned cycleCount = 0;
    int unsigned returnDue [$];
    int unsigned seedValue;
    int          rowIdx;
    int          repIdx;

    spriteRender #(
        .FrameWidth   (FrameWidth),
        .FrameHeight  (FrameHeight),
        .AttackLength (AttackLength),
        .StepSize     (StepSize),
        .CreditDepth  (CreditDepth)
    ) dut_i (
        .Clk          (Clk),
        .rst          (rst),
        .frameTick    (frameTick),
        .keycode      (keycode),
        .creditReturn (creditReturn),
        .pixelValid   (pixelValid),
        .pixel        (pixel)
    );

    renderChecker #(
        .FrameWidth   (FrameWidth),
        .FrameHeight  (FrameHeight),
        .AttackLength (AttackLength),
        .StepSize     (StepSize),
        .CreditDepth  (CreditDepth)
    ) renderChecker_i (
        .Clk          (Clk),
        .rst          (rst),
        .frameKick    (frameKick),
        .frameKey     (frameKey),
        .frameAttack  (frameAttack),
        .pixelValid   (pixelValid),
        .pixel        (pixel),
        .creditReturn (creditReturn)
    );

    initial begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;
    end

    // Line buffer model, every accepted pixel gets a credit back later
    initial begin
        seedValue = $urandom(72);
        forever begin
            @(posedge Clk);
            cycleCount++;
            if (!rst && pixelValid) begin
                returnDue.push_back(cycleCount + ($urandom % 4));
            end
        end
    end

    // At most one credit per cycle, in acceptance order
    always @(negedge Clk) begin
        if (!rst && returnDue.size() != 0 && returnDue[0] <= cycleCount) begin
            void'(returnDue.pop_front());
            creditReturn = 1'b1;
        end else begin
            creditReturn = 1'b0;
        end
    end

    function automatic stimRowT makeRow(logic [7:0] key, logic attack, int reps, logic midTick);
        stimRowT row;
        row.key     = key;
        row.attack  = attack;
        row.reps    = 4'(reps);
        row.midTick = midTick;
        return row;
    endfunction

    task automatic fillRows();
        // Attack in each facing, then clamp at the top left corner
        stimRows[0]  = makeRow(KeySpace, 1'b1, 1, 1'b0);
        stimRows[1]  = makeRow(KeyD, 1'b0, 1, 1'b0);
        stimRows[2]  = makeRow(KeySpace, 1'b1, 1, 1'b0);
        stimRows[3]  = makeRow(KeyS, 1'b0, 1, 1'b0);
        stimRows[4]  = makeRow(KeyA, 1'b0, 1, 1'b0);
        stimRows[5]  = makeRow(KeySpace, 1'b1, 1, 1'b0);
        stimRows[6]  = makeRow(KeyW, 1'b0, 1, 1'b0);
        stimRows[7]  = makeRow(KeySpace, 1'b1, 1, 1'b0);
        stimRows[8]  = makeRow(8'h00, 1'b0, 1, 1'b0);
        stimRows[9]  = makeRow(KeyA, 1'b0, 7, 1'b0);
        stimRows[10] = makeRow(KeyW, 1'b0, 5, 1'b0);
        stimRows[11] = makeRow(KeySpace, 1'b1, 1, 1'b0);
        stimRows[12] = makeRow(KeyD, 1'b0, 1, 1'b1);
        stimRows[13] = makeRow(8'h00, 1'b0, 1, 1'b0);
    endtask

    task automatic runFrame(stimRowT row);
        int   waited;
        int   seen;
        logic sawLast;
        logic midSent;
        waited  = 0;
        seen    = 0;
        sawLast = 1'b0;
        midSent = 1'b0;
        @(negedge Clk);
        keycode     = row.key;
        frameKey    = row.key;
        frameAttack = row.attack;
        frameKick   = 1'b1;
        frameTick   = 1'b1;
        @(negedge Clk);
        frameKick = 1'b0;
        frameTick = 1'b0;
        while (!sawLast && waited < FrameTimeout) begin
            @(negedge Clk);
            waited++;
            frameTick = 1'b0;
            if (pixelValid) begin
                seen++;
                sawLast = pixel.last;
            end
            // Second tick halfway through the frame, key still held
            if (row.midTick && !midSent && seen == FramePixels / 2) begin
                frameTick = 1'b1;
                midSent   = 1'b1;
            end
        end
        if (!sawLast) begin
            $display("Timeout: no last pixel within %0d cycles, %0d pixels seen",
                     FrameTimeout, seen);
            timedOut = 1'b1;
        end
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        while (returnDue.size() != 0 && waited < DrainTimeout) begin
            @(negedge Clk);
            waited++;
        end
        if (returnDue.size() != 0) begin
            $display("Timeout: %0d credits still pending after the last frame",
                     returnDue.size());
            timedOut = 1'b1;
        end
    endtask

    initial begin
        rst          = 1'b1;
        frameTick    = 1'b0;
        keycode      = 8'h00;
        creditReturn = 1'b0;
        frameKick    = 1'b0;
        frameKey     = 8'h00;
        frameAttack  = 1'b0;
        timedOut     = 1'b0;
        fillRows();
        repeat (3) @(posedge Clk);
        @(negedge Clk);
        rst = 1'b0;
        for (rowIdx = 0; rowIdx < RowCount; rowIdx++) begin
            for (repIdx = 0; repIdx < int'(stimRows[rowIdx].reps); repIdx++) begin
                if (!timedOut) begin
                    runFrame(stimRows[rowIdx]);
                end
            end
        end
        if (!timedOut) begin
            waitDrain();
        end
        // Let the checker see the final credit return
        @(posedge Clk);
        @(negedge Clk);
        renderChecker_i.finishChecks();
        if (!timedOut && renderChecker_i.totalErrors() == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
